/* flist.f */
hw/pcGenPkg.sv
hw/branchHistory.sv
hw/returnStack.sv
hw/branchPredict.sv
hw/pcGenerate.sv
testbench/pcGenerateTb.sv

/* hw/branchHistory.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch history counters
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module branchHistory #(
	parameter int BHT_ENTRIES = 64
) (
	input logic CLK,
	input logic rst,
	input logic [pcGenPkg::XLEN-1:0] lookupPc,
	input logic trainValid,
	input logic [pcGenPkg::XLEN-1:0] trainPc,
	input logic trainTaken,
	output logic predTaken
);

	localparam int IDX_W = (BHT_ENTRIES > 1) ? $clog2(BHT_ENTRIES) : 1;

	// 2-bit saturating counters
	logic [1:0] counter [BHT_ENTRIES];

	logic [IDX_W-1:0] lookupIdx;
	logic [IDX_W-1:0] trainIdx;
	logic [1:0] trainCnt;

	// bit 0 is always clear, index starts at bit 1
	assign lookupIdx = lookupPc[IDX_W:1];
	assign trainIdx = trainPc[IDX_W:1];

	// combinational read, msb is the guess
	assign predTaken = counter[lookupIdx][1];
	assign trainCnt = counter[trainIdx];

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// training
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK) begin
		if (rst) begin
			// weakly not taken
			for (int i = 0; i < BHT_ENTRIES; i++) begin
				counter[i] <= 2'b01;
			end
		end else if (trainValid) begin
			// one step toward the outcome, saturate at 0 and 3
			if (trainTaken && (trainCnt != 2'b11)) begin
				counter[trainIdx] <= trainCnt + 2'd1;
			end else if (!trainTaken && (trainCnt != 2'b00)) begin
				counter[trainIdx] <= trainCnt - 2'd1;
			end
		end
	end

endmodule

/* hw/branchPredict.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// next-pc select and branch queue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module branchPredict #(
	parameter pcGenPkg::addrT RESET_PC = 64'h8000_0000,
	parameter int BRANCH_DEPTH = 4
) (
	input logic CLK,
	input logic rst,
	input logic privileged_valid,
	input pcGenPkg::addrT privileged_pc,
	input logic jalr_valid,
	input pcGenPkg::addrT jalr_pc,
	input logic bru_res_valid,
	input logic bru_takenBranch,
	input logic fetch_pc_valid,
	input pcGenPkg::addrT fetch_pc_queue,
	input logic isJal,
	input logic isJalr,
	input logic isBranch,
	input logic isCall,
	input logic isReturn,
	input logic isRVC,
	input logic [pcGenPkg::XLEN-1:0] imm,
	output logic isMisPredict,
	output logic fetch_addr_valid,
	output pcGenPkg::addrT fetch_addr_qout,
	input logic pcGen_fetch_ready,
	input logic predTaken,
	output pcGenPkg::addrT lookupPc,
	output logic trainValid,
	output pcGenPkg::addrT trainPc,
	output logic trainTaken,
	output logic push,
	output pcGenPkg::addrT pushAddr,
	output logic pop,
	input pcGenPkg::addrT popAddr
);

	import pcGenPkg::*;

	localparam int PTR_W = (BRANCH_DEPTH > 1) ? $clog2(BRANCH_DEPTH) : 1;
	localparam int CNT_W = $clog2(BRANCH_DEPTH + 1);

	// fetch address and control
	addrT fetchAddr;
	logic addrValid;
	logic bootPend;
	logic misPredictQ;
	logic jalrWait;

	// branch parked while the queue is full
	logic heldValid;
	logic heldPred;
	addrT heldAddr;
	addrT heldAlt;
	addrT heldPc;

	// outstanding branch queue
	logic qPred [BRANCH_DEPTH];
	addrT qAlt [BRANCH_DEPTH];
	addrT qPc [BRANCH_DEPTH];
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W-1:0] wrPtr;
	logic [CNT_W-1:0] qCount;

	// next-pc datapath
	addrT instLen;
	addrT seqPc;
	addrT tgtPc;
	addrT predPc;
	addrT altPc;
	addrT nextPc;

	// per-cycle events
	logic resolve;
	logic misRedirect;
	logic correct;
	logic jalrTake;
	logic fetchTake;
	logic qFull;
	logic holdFetch;
	logic relHeld;
	logic enq;
	logic enqPred;
	addrT enqAlt;
	addrT enqPc;

	function automatic logic [PTR_W-1:0] ptrInc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(BRANCH_DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next-pc calculation
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// rvc only picks the step, no realignment
	assign instLen = addrT'(isRVC ? 2 : 4);
	assign seqPc = fetch_pc_queue + instLen;
	assign tgtPc = fetch_pc_queue + imm;

	// counter msb set means taken
	assign predPc = predTaken ? tgtPc : seqPc;
	assign altPc = predTaken ? seqPc : tgtPc;

	always_comb begin
		if (isJal) begin
			nextPc = tgtPc;
		end else if (isJalr) begin
			// only a return gets here with an address
			nextPc = popAddr;
		end else if (isBranch) begin
			nextPc = predPc;
		end else begin
			nextPc = seqPc;
		end
	end

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// event priority
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// oldest entry resolved this cycle
	assign resolve = bru_res_valid && (qCount != '0);
	assign correct = resolve && (qPred[rdPtr] == bru_takenBranch);
	// exception wins over a wrong guess
	assign misRedirect = resolve && !correct && !privileged_valid;
	assign jalrTake = jalr_valid && jalrWait && !privileged_valid && !misRedirect;
	assign fetchTake = fetch_pc_valid && !privileged_valid && !misRedirect && !jalrTake;

	// a correct resolution this cycle frees a slot
	assign qFull = (qCount == CNT_W'(BRANCH_DEPTH)) && !correct;
	assign holdFetch = fetchTake && isBranch && qFull;
	assign relHeld = heldValid && correct && !privileged_valid;

	assign enq = (fetchTake && isBranch && !qFull) || relHeld;
	assign enqPred = relHeld ? heldPred : predTaken;
	assign enqAlt = relHeld ? heldAlt : altPc;
	assign enqPc = relHeld ? heldPc : fetch_pc_queue;

	// return stack, speculative only
	assign push = fetchTake && isCall && (isJal || isJalr);
	assign pushAddr = seqPc;
	assign pop = fetchTake && isJalr && isReturn;

	// counter lookup and training
	assign lookupPc = fetch_pc_queue;
	assign trainValid = resolve;
	assign trainPc = qPc[rdPtr];
	assign trainTaken = bru_takenBranch;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fetch address register
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK) begin
		if (rst) begin
			fetchAddr <= RESET_PC;
			addrValid <= 1'b0;
			bootPend <= 1'b1;
			misPredictQ <= 1'b0;
			jalrWait <= 1'b0;
			heldValid <= 1'b0;
		end else begin
			bootPend <= 1'b0;
			misPredictQ <= misRedirect;
			// accepted, low until the next address
			if (addrValid && pcGen_fetch_ready) begin
				addrValid <= 1'b0;
			end
			// first address after reset
			if (bootPend) begin
				addrValid <= 1'b1;
			end
			if (privileged_valid) begin
				fetchAddr <= privileged_pc;
				addrValid <= 1'b1;
				jalrWait <= 1'b0;
				heldValid <= 1'b0;
			end else if (misRedirect) begin
				fetchAddr <= qAlt[rdPtr];
				addrValid <= 1'b1;
				jalrWait <= 1'b0;
				heldValid <= 1'b0;
			end else if (jalrTake) begin
				fetchAddr <= jalr_pc;
				addrValid <= 1'b1;
				jalrWait <= 1'b0;
			end else if (relHeld) begin
				fetchAddr <= heldAddr;
				addrValid <= 1'b1;
				heldValid <= 1'b0;
			end else if (fetchTake) begin
				if (isJalr && !isReturn) begin
					// target comes from execute
					jalrWait <= 1'b1;
				end else if (holdFetch) begin
					heldValid <= 1'b1;
				end else begin
					fetchAddr <= nextPc;
					addrValid <= 1'b1;
				end
			end
		end
	end

	// parked branch payload
	always_ff @(posedge CLK) begin
		if (holdFetch) begin
			heldAddr <= predPc;
			heldAlt <= altPc;
			heldPc <= fetch_pc_queue;
			heldPred <= predTaken;
		end
	end

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// outstanding branch queue
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK) begin
		if (rst || privileged_valid || misRedirect) begin
			// flush on any redirect that kills younger branches
			rdPtr <= '0;
			wrPtr <= '0;
			qCount <= '0;
		end else begin
			if (resolve) begin
				rdPtr <= ptrInc(rdPtr);
			end
			if (enq) begin
				wrPtr <= ptrInc(wrPtr);
			end
			qCount <= qCount + CNT_W'(enq) - CNT_W'(resolve);
		end
	end

	always_ff @(posedge CLK) begin
		if (enq) begin
			qPred[wrPtr] <= enqPred;
			qAlt[wrPtr] <= enqAlt;
			qPc[wrPtr] <= enqPc;
		end
	end

	// outputs
	assign fetch_addr_valid = addrValid;
	assign fetch_addr_qout = fetchAddr;
	assign isMisPredict = misPredictQ;

endmodule

/* hw/pcGenPkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// next-pc generator shared definitions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pcGenPkg;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// rv64 address width
	localparam int XLEN = 64;

	// pre-decode word from the instruction queue
	// six flag bits on top of a full-width immediate
	localparam int PREDECODE_W = 70;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pre-decode field positions
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// unconditional jump with immediate
	localparam int PD_JAL = 69;
	// indirect jump
	localparam int PD_JALR = 68;
	// conditional branch
	localparam int PD_BRANCH = 67;
	// link register written, push return address
	localparam int PD_CALL = 66;
	// jalr through ra, pop return address
	localparam int PD_RETURN = 65;
	// compressed encoding, step of 2
	localparam int PD_RVC = 64;
	// lsb of the immediate, XLEN bits wide
	localparam int PD_IMM = 0;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// types
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// instruction address
	typedef logic [XLEN-1:0] addrT;

endpackage

/* hw/pcGenerate.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// next-pc generator top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pcGenerate #(
	parameter pcGenPkg::addrT RESET_PC = 64'h8000_0000,
	parameter int BHT_ENTRIES = 64,
	parameter int RAS_DEPTH = 8,
	parameter int BRANCH_DEPTH = 4
) (
	input logic CLK,
	input logic rst,

	// exception redirect
	input logic privileged_valid,
	input pcGenPkg::addrT privileged_pc,

	// jalr target from execute
	input logic jalr_valid,
	input pcGenPkg::addrT jalr_pc,

	// branch resolution, oldest first
	input logic bru_res_valid,
	input logic bru_takenBranch,

	// returned instruction from the instruction queue
	input logic fetch_pc_valid,
	input pcGenPkg::addrT fetch_pc_queue,
	input logic [pcGenPkg::PREDECODE_W-1:0] preDecode_info,

	// flush strobe
	output logic isMisPredict,

	// fetch address handshake
	output logic fetch_addr_valid,
	output pcGenPkg::addrT fetch_addr_qout,
	input logic pcGen_fetch_ready
);

	import pcGenPkg::*;

	// decoded pre-decode fields
	logic isJal;
	logic isJalr;
	logic isBranch;
	logic isCall;
	logic isReturn;
	logic isRVC;
	logic [XLEN-1:0] imm;

	// counter table link
	logic predTaken;
	addrT lookupPc;
	logic trainValid;
	addrT trainPc;
	logic trainTaken;

	// return stack link
	logic push;
	addrT pushAddr;
	logic pop;
	addrT popAddr;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pre-decode split
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign isJal = preDecode_info[PD_JAL];
	assign isJalr = preDecode_info[PD_JALR];
	assign isBranch = preDecode_info[PD_BRANCH];
	assign isCall = preDecode_info[PD_CALL];
	assign isReturn = preDecode_info[PD_RETURN];
	assign isRVC = preDecode_info[PD_RVC];
	assign imm = preDecode_info[PD_IMM +: XLEN];

	// address register, next-pc select and branch queue
	branchPredict #(
		.RESET_PC(RESET_PC),
		.BRANCH_DEPTH(BRANCH_DEPTH)
	) iBranchPredict (
		.CLK(CLK),
		.rst(rst),
		.privileged_valid(privileged_valid),
		.privileged_pc(privileged_pc),
		.jalr_valid(jalr_valid),
		.jalr_pc(jalr_pc),
		.bru_res_valid(bru_res_valid),
		.bru_takenBranch(bru_takenBranch),
		.fetch_pc_valid(fetch_pc_valid),
		.fetch_pc_queue(fetch_pc_queue),
		.isJal(isJal),
		.isJalr(isJalr),
		.isBranch(isBranch),
		.isCall(isCall),
		.isReturn(isReturn),
		.isRVC(isRVC),
		.imm(imm),
		.isMisPredict(isMisPredict),
		.fetch_addr_valid(fetch_addr_valid),
		.fetch_addr_qout(fetch_addr_qout),
		.pcGen_fetch_ready(pcGen_fetch_ready),
		.predTaken(predTaken),
		.lookupPc(lookupPc),
		.trainValid(trainValid),
		.trainPc(trainPc),
		.trainTaken(trainTaken),
		.push(push),
		.pushAddr(pushAddr),
		.pop(pop),
		.popAddr(popAddr)
	);

	// 2-bit counter table
	branchHistory #(
		.BHT_ENTRIES(BHT_ENTRIES)
	) iBranchHistory (
		.CLK(CLK),
		.rst(rst),
		.lookupPc(lookupPc),
		.trainValid(trainValid),
		.trainPc(trainPc),
		.trainTaken(trainTaken),
		.predTaken(predTaken)
	);

	// return address stack
	returnStack #(
		.RAS_DEPTH(RAS_DEPTH)
	) iReturnStack (
		.CLK(CLK),
		.rst(rst),
		.push(push),
		.pushAddr(pushAddr),
		.pop(pop),
		.popAddr(popAddr)
	);

endmodule

/* hw/returnStack.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// return address stack
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module returnStack #(
	parameter int RAS_DEPTH = 8
) (
	input logic CLK,
	input logic rst,
	input logic push,
	input pcGenPkg::addrT pushAddr,
	input logic pop,
	output pcGenPkg::addrT popAddr
);

	import pcGenPkg::*;

	localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;

	// circular storage, oldest overwritten on overflow
	addrT stack [RAS_DEPTH];

	// next free slot
	logic [PTR_W-1:0] ptr;
	// most recent entry
	logic [PTR_W-1:0] topPtr;

	// depth is a power of two so the pointer wraps by itself
	assign topPtr = ptr - 1'b1;

	// popped value visible in the pop cycle
	assign popAddr = stack[topPtr];

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// push / pop
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK) begin
		if (rst) begin
			ptr <= '0;
			for (int i = 0; i < RAS_DEPTH; i++) begin
				stack[i] <= '0;
			end
		end else if (push) begin
			// write then advance
			stack[ptr] <= pushAddr;
			ptr <= ptr + 1'b1;
		end else if (pop) begin
			// step back, entry stays for a later overflow read
			ptr <= topPtr;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# build and run the next-pc generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module pcGenerateTb \
	-f flist.f \
	--Mdir obj_dir \
	-o simPcGenerate
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/simPcGenerate
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

exit 0

/* testbench/pcGenerateTb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// next-pc generator testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pcGenerateTb;

	import pcGenPkg::*;

	localparam addrT RESET_PC = 64'h8000_0000;
	localparam int BHT_ENTRIES = 64;
	localparam int RAS_DEPTH = 8;
	localparam int BRANCH_DEPTH = 4;
	localparam int IDX_W = $clog2(BHT_ENTRIES);
	localparam int NUM_FETCH = 3000;
	localparam int MAX_CYCLES = 200000;
	localparam int IDLE_LIMIT = 500;

	// dut inputs
	logic clk = 1'b0;
	logic rst;
	logic privValid;
	addrT privPc;
	logic jalrValid;
	addrT jalrPc;
	logic resValid;
	logic resTaken;
	logic fetchValid;
	addrT fetchPc;
	logic [PREDECODE_W-1:0] preDecode;
	logic ready;
	// dut outputs
	logic isMisPredict;
	logic addrValid;
	addrT addrOut;

	// reference model state
	logic mValid;
	logic mBoot;
	logic mMis;
	addrT mAddr;
	logic mJalrWait;
	logic mHeld;
	logic mHeldPred;
	addrT mHeldAddr;
	addrT mHeldAlt;
	addrT mHeldPc;
	logic [1:0] counters [BHT_ENTRIES];
	addrT rasMem [RAS_DEPTH];
	int rasPtr;
	// outstanding branches, oldest first
	logic bqPred [$];
	addrT bqAlt [$];
	addrT bqPc [$];

	// environment state
	logic pendActive;
	int pendDelay;
	addrT pendPc;
	int jalrDelay;
	logic holdCheck;
	addrT holdAddr;
	logic [31:0] rngState;
	int acceptCount;
	int misCount;
	int excCount;
	int idleCycles;
	int cycles;

	pcGenerate #(
		.RESET_PC(RESET_PC),
		.BHT_ENTRIES(BHT_ENTRIES),
		.RAS_DEPTH(RAS_DEPTH),
		.BRANCH_DEPTH(BRANCH_DEPTH)
	) dut (
		.CLK(clk),
		.rst(rst),
		.privileged_valid(privValid),
		.privileged_pc(privPc),
		.jalr_valid(jalrValid),
		.jalr_pc(jalrPc),
		.bru_res_valid(resValid),
		.bru_takenBranch(resTaken),
		.fetch_pc_valid(fetchValid),
		.fetch_pc_queue(fetchPc),
		.preDecode_info(preDecode),
		.isMisPredict(isMisPredict),
		.fetch_addr_valid(addrValid),
		.fetch_addr_qout(addrOut),
		.pcGen_fetch_ready(ready)
	);

	always #5 clk = ~clk;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// xorshift32 step
	function automatic logic [31:0] randWord();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// halfword aligned random address
	function automatic addrT randAddr();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = randWord();
		lo = randWord();
		return {hi, lo[31:1], 1'b0};
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic mismatch(input string sig, input logic [63:0] got, input logic [63:0] exp);
		failRun($sformatf("MISMATCH %s got %h expected %h", sig, got, exp));
	endtask

	// random instruction kind and short signed offset
	function automatic logic [PREDECODE_W-1:0] randomInstruction();
		logic [PREDECODE_W-1:0] pd;
		logic [31:0] r;
		r = randWord();
		pd = '0;
		pd[PD_IMM +: XLEN] = {{51{r[31]}}, r[31:20], 1'b0};
		pd[PD_RVC] = r[4];
		// calls a bit more often than returns, so the stack wraps
		case (r[3:0])
			4'd5, 4'd6: pd[PD_JAL] = 1'b1;
			4'd7, 4'd8: begin
				pd[PD_JAL] = 1'b1;
				pd[PD_CALL] = 1'b1;
			end
			4'd9, 4'd10: begin
				pd[PD_JALR] = 1'b1;
				pd[PD_RETURN] = 1'b1;
			end
			4'd11: pd[PD_JALR] = 1'b1;
			4'd12: begin
				pd[PD_JALR] = 1'b1;
				pd[PD_CALL] = 1'b1;
			end
			4'd13, 4'd14, 4'd15: pd[PD_BRANCH] = 1'b1;
			// 0 to 4 stay sequential
			default: ;
		endcase
		return pd;
	endfunction

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic predictTaken(input addrT pc);
		return counters[int'(pc[IDX_W:1])][1];
	endfunction

	// saturating step toward the outcome
	task automatic trainCounter(input addrT pc, input logic taken);
		int idx;
		idx = int'(pc[IDX_W:1]);
		if (taken && counters[idx] != 2'd3) begin
			counters[idx] = counters[idx] + 2'd1;
		end else if (!taken && counters[idx] != 2'd0) begin
			counters[idx] = counters[idx] - 2'd1;
		end
	endtask

	task automatic rasPush(input addrT a);
		rasMem[rasPtr] = a;
		rasPtr = (rasPtr + 1) % RAS_DEPTH;
	endtask

	function automatic addrT rasPop();
		rasPtr = (rasPtr + RAS_DEPTH - 1) % RAS_DEPTH;
		return rasMem[rasPtr];
	endfunction

	// exception or misprediction kills everything younger
	task automatic flushPath(input addrT target);
		mAddr = target;
		mValid = 1'b1;
		mJalrWait = 1'b0;
		mHeld = 1'b0;
		pendActive = 1'b0;
		bqPred.delete();
		bqAlt.delete();
		bqPc.delete();
	endtask

	// next address for the returned instruction
	task automatic applyInstruction();
		addrT imm;
		addrT seq;
		addrT tgt;
		logic taken;
		imm = preDecode[PD_IMM +: XLEN];
		seq = fetchPc + (preDecode[PD_RVC] ? 64'd2 : 64'd4);
		tgt = fetchPc + imm;
		if (preDecode[PD_JAL]) begin
			if (preDecode[PD_CALL]) begin
				rasPush(seq);
			end
			mAddr = tgt;
			mValid = 1'b1;
		end else if (preDecode[PD_JALR] && preDecode[PD_RETURN]) begin
			mAddr = rasPop();
			mValid = 1'b1;
		end else if (preDecode[PD_JALR]) begin
			if (preDecode[PD_CALL]) begin
				rasPush(seq);
			end
			// execute supplies the target later
			mJalrWait = 1'b1;
			jalrDelay = int'(randWord() % 32'd4);
		end else if (preDecode[PD_BRANCH]) begin
			taken = predictTaken(fetchPc);
			if (bqPred.size() < BRANCH_DEPTH) begin
				bqPred.push_back(taken);
				bqAlt.push_back(taken ? seq : tgt);
				bqPc.push_back(fetchPc);
				mAddr = taken ? tgt : seq;
				mValid = 1'b1;
			end else begin
				// queue full, park until a slot frees
				mHeld = 1'b1;
				mHeldPred = taken;
				mHeldAddr = taken ? tgt : seq;
				mHeldAlt = taken ? seq : tgt;
				mHeldPc = fetchPc;
			end
		end else begin
			mAddr = seq;
			mValid = 1'b1;
		end
	endtask

	// one clock edge with the inputs sampled there
	task automatic stepModel();
		logic accept;
		logic resolve;
		logic wrong;
		addrT trainPc;
		accept = mValid && ready;
		holdCheck = mValid && !ready;
		holdAddr = mAddr;
		resolve = resValid && (bqPred.size() != 0);
		wrong = resolve && (bqPred[0] != resTaken);
		trainPc = resolve ? bqPc[0] : '0;
		if (accept) begin
			// instruction queue picks up the accepted address
			pendActive = 1'b1;
			pendDelay = int'(randWord() % 32'd4);
			pendPc = mAddr;
			mValid = 1'b0;
			acceptCount++;
			idleCycles = 0;
		end
		if (mBoot) begin
			mValid = 1'b1;
			mBoot = 1'b0;
		end
		mMis = 1'b0;
		if (privValid) begin
			excCount++;
			holdCheck = 1'b0;
			flushPath(privPc);
		end else if (wrong) begin
			misCount++;
			holdCheck = 1'b0;
			mMis = 1'b1;
			flushPath(bqAlt[0]);
		end else begin
			if (resolve) begin
				void'(bqPred.pop_front());
				void'(bqAlt.pop_front());
				void'(bqPc.pop_front());
			end
			if (jalrValid && mJalrWait) begin
				mAddr = jalrPc;
				mValid = 1'b1;
				mJalrWait = 1'b0;
			end else if (mHeld && resolve) begin
				bqPred.push_back(mHeldPred);
				bqAlt.push_back(mHeldAlt);
				bqPc.push_back(mHeldPc);
				mAddr = mHeldAddr;
				mValid = 1'b1;
				mHeld = 1'b0;
			end else if (fetchValid) begin
				applyInstruction();
			end
		end
		// lookups above saw the old counters
		if (resolve) begin
			trainCounter(trainPc, resTaken);
		end
	endtask

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks and stimulus
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic checkOutputs();
		assert (addrValid === mValid)
			else mismatch("fetch_addr_valid", 64'(addrValid), 64'(mValid));
		if (mValid) begin
			assert (addrOut === mAddr)
				else mismatch("fetch_addr_qout", addrOut, mAddr);
		end
		assert (isMisPredict === mMis)
			else mismatch("isMisPredict", 64'(isMisPredict), 64'(mMis));
		// stalled address must not move
		if (holdCheck) begin
			assert (addrOut === holdAddr)
				else mismatch("fetch_addr_qout", addrOut, holdAddr);
		end
		// first accepted address out of reset
		if (addrValid && ready && acceptCount == 0) begin
			assert (addrOut === RESET_PC)
				else mismatch("fetch_addr_qout", addrOut, RESET_PC);
		end
	endtask

	task automatic driveInputs();
		logic [31:0] r;
		// fetch back-pressure, ready 3 of 4
		r = randWord();
		ready <= (r[1:0] != 2'b00);
		// instruction queue return
		if (pendActive && pendDelay == 0) begin
			fetchValid <= 1'b1;
			fetchPc <= pendPc;
			preDecode <= randomInstruction();
			pendActive = 1'b0;
		end else begin
			fetchValid <= 1'b0;
			if (pendActive) begin
				pendDelay--;
			end
		end
		// execute answers the jalr wait
		if (mJalrWait && jalrDelay == 0) begin
			jalrValid <= 1'b1;
			jalrPc <= randAddr();
		end else begin
			jalrValid <= 1'b0;
			if (mJalrWait) begin
				jalrDelay--;
			end
		end
		// branch unit resolves slowly so the queue fills up
		r = randWord();
		if (bqPred.size() != 0 && r[4:0] == 5'd0) begin
			// outcomes mostly taken
			resValid <= 1'b1;
			resTaken <= (r[6:5] != 2'b00);
		end else begin
			resValid <= 1'b0;
		end
		// rare exception once fetch is running
		r = randWord();
		if (acceptCount != 0 && r[6:0] == 7'd0) begin
			privValid <= 1'b1;
			privPc <= randAddr();
		end else begin
			privValid <= 1'b0;
		end
	endtask

	initial begin
		rngState = 32'h846a;
		rst = 1'b1;
		privValid = 1'b0;
		privPc = '0;
		jalrValid = 1'b0;
		jalrPc = '0;
		resValid = 1'b0;
		resTaken = 1'b0;
		fetchValid = 1'b0;
		fetchPc = '0;
		preDecode = '0;
		ready = 1'b0;
		// model in its reset state
		mValid = 1'b0;
		mBoot = 1'b1;
		mMis = 1'b0;
		mAddr = RESET_PC;
		mJalrWait = 1'b0;
		mHeld = 1'b0;
		for (int i = 0; i < BHT_ENTRIES; i++) begin
			counters[i] = 2'd1;
		end
		for (int i = 0; i < RAS_DEPTH; i++) begin
			rasMem[i] = '0;
		end
		rasPtr = 0;
		pendActive = 1'b0;
		holdCheck = 1'b0;
		acceptCount = 0;
		misCount = 0;
		excCount = 0;
		idleCycles = 0;
		cycles = 0;

		// outputs stay low in reset
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			if (i > 0) begin
				assert (addrValid === 1'b0)
					else mismatch("fetch_addr_valid", 64'(addrValid), 64'd0);
				assert (isMisPredict === 1'b0)
					else mismatch("isMisPredict", 64'(isMisPredict), 64'd0);
			end
			if (i == 4) begin
				rst <= 1'b0;
			end
		end

		while (acceptCount < NUM_FETCH && cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
			idleCycles++;
			checkOutputs();
			stepModel();
			driveInputs();
			if (idleCycles > IDLE_LIMIT) begin
				failRun("no fetch address was accepted for too many cycles");
			end
		end

		$display("accepted %0d, mispredicts %0d, exceptions %0d, cycles %0d",
			acceptCount, misCount, excCount, cycles);
		if (acceptCount >= NUM_FETCH) begin
			$display("Simulation passed");
			$finish;
		end else begin
			failRun("cycle limit reached before all fetches were accepted");
		end
	end

endmodule
